// File: include/softermax_cfg.svh
//////////////////////////////////////////////////////////////////////
// Softermax local window configuration
// Lane count, fixed-point widths and input FIFO depth
//////////////////////////////////////////////////////////////////////

`ifndef SOFTERMAX_CFG_SVH
`define SOFTERMAX_CFG_SVH

// Lanes per window, a power of two of at least 2
`define SMX_PARALLELISM 4

// Signed fixed-point scores
`define SMX_IN_WIDTH 8
`define SMX_IN_FRAC 4

// Unsigned power-of-two results
`define SMX_OUT_WIDTH 8
`define SMX_OUT_FRAC 4

// Input FIFO depth in windows
`define SMX_FIFO_DEPTH 16

// Integer part of a score after flooring
`define SMX_MAX_WIDTH (`SMX_IN_WIDTH - `SMX_IN_FRAC)

`endif

// File: source/softermax_pkg.sv
//////////////////////////////////////////////////////////////////////
// Softermax shared types
// Fixed-point vector types and the 2^(k/2^frac) table function
//////////////////////////////////////////////////////////////////////

`include "softermax_cfg.svh"

package softermax_pkg;

  // Raw score, signed with SMX_IN_FRAC fraction bits
  typedef logic signed [`SMX_IN_WIDTH-1:0] smx_in_t;

  // Floored score, integer only
  typedef logic signed [`SMX_MAX_WIDTH-1:0] smx_int_t;

  // Score minus max, one extra bit so the subtraction cannot wrap
  typedef logic signed [`SMX_IN_WIDTH:0] smx_diff_t;

  // Power-of-two result with SMX_OUT_FRAC fraction bits
  typedef logic [`SMX_OUT_WIDTH-1:0] smx_out_t;

  // Entry k holds 2^(k / 2^SMX_IN_FRAC) scaled to the output format
  function automatic smx_out_t pow2_frac_entry(input int k);
    real scaled;
    scaled = (2.0 ** (real'(k) / real'(2 ** `SMX_IN_FRAC))) * real'(2 ** `SMX_OUT_FRAC);
    return smx_out_t'($rtoi(scaled + 0.5));
  endfunction

endpackage

// File: source/softermax_sub_if.sv
//////////////////////////////////////////////////////////////////////
// Subtract stage stream
// Per-lane differences and the window max, with valid/ready
//////////////////////////////////////////////////////////////////////

`include "softermax_cfg.svh"

interface softermax_sub_if;

  softermax_pkg::smx_diff_t diff [`SMX_PARALLELISM];
  softermax_pkg::smx_int_t  max;
  logic                     valid;
  logic                     ready;

  modport src (output diff, output max, output valid, input ready);

  modport dst (input diff, input max, input valid, output ready);

endinterface

// File: source/skid_buffer.sv
//////////////////////////////////////////////////////////////////////
// Skid buffer
// Two-entry valid/ready register slice with a registered in_ready
//////////////////////////////////////////////////////////////////////

module skid_buffer #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [width-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [width-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic [width-1:0] skid_data;
  logic             skid_valid;
  logic             skid_valid_next;
  logic             in_fire;
  logic             main_free;

  assign in_fire   = in_valid && in_ready;
  assign main_free = !out_valid || out_ready;

  // Skid fills only when a beat lands while the output is stalled
  always_comb begin
    skid_valid_next = skid_valid;
    if (main_free) begin
      skid_valid_next = 1'b0;
    end else if (in_fire) begin
      skid_valid_next = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      skid_valid <= skid_valid_next;
      in_ready   <= !skid_valid_next;
      if (main_free) begin
        out_valid <= skid_valid || in_fire;
      end
    end
  end

  // Skid entry drains first to keep order
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        out_data <= skid_data;
      end else if (in_fire) begin
        out_data <= in_data;
      end
    end else if (in_fire) begin
      skid_data <= in_data;
    end
  end

  a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: source/sync_fifo.sv
//////////////////////////////////////////////////////////////////////
// Synchronous FIFO
// First-word-fall-through circular buffer with valid/ready on
// both sides
//////////////////////////////////////////////////////////////////////

module sync_fifo #(
  parameter int width = 8,
  parameter int depth = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [width-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [width-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Pointer wrap for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready  = (count != cnt_w'(depth));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Count stays within depth and agrees with the pointer distance
  a_count_bound : assert property (@(posedge clk) disable iff (!rst_n)
    count <= cnt_w'(depth) &&
    (int'(count) % depth == (int'(wr_ptr) - int'(rd_ptr) + depth) % depth));

endmodule

// File: source/max_tree.sv
//////////////////////////////////////////////////////////////////////
// Max tree
// Pipelined signed maximum over one window, one register level
// per tree level, all levels stalling together
//////////////////////////////////////////////////////////////////////

`include "softermax_cfg.svh"

module max_tree (
  input  logic                    clk,
  input  logic                    rst_n,
  input  softermax_pkg::smx_int_t in_data [`SMX_PARALLELISM],
  input  logic                    in_valid,
  output logic                    in_ready,
  output softermax_pkg::smx_int_t out_data,
  output logic                    out_valid,
  input  logic                    out_ready
);

  localparam int lanes  = `SMX_PARALLELISM;
  localparam int levels = $clog2(lanes);

  // Heap layout: node 1 is the root, node n has children 2n and 2n+1
  softermax_pkg::smx_int_t node_q   [1:lanes-1];
  softermax_pkg::smx_int_t child_lo [1:lanes-1];
  softermax_pkg::smx_int_t child_hi [1:lanes-1];
  logic [levels-1:0]       level_valid;
  logic                    advance;

  assign out_valid = level_valid[levels-1];
  assign out_data  = node_q[1];

  // Whole pipe moves when the root is empty or being taken
  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;

  for (genvar n = 1; n < lanes; n++) begin : g_node
    if (2 * n >= lanes) begin : g_leaf
      assign child_lo[n] = in_data[2 * n - lanes];
      assign child_hi[n] = in_data[2 * n + 1 - lanes];
    end else begin : g_inner
      assign child_lo[n] = node_q[2 * n];
      assign child_hi[n] = node_q[2 * n + 1];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int n = 1; n < lanes; n++) begin
        node_q[n] <= (child_lo[n] > child_hi[n]) ? child_lo[n] : child_hi[n];
      end
    end
  end

  // Bit 0 tracks the leaf level, top bit tracks the root
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level_valid <= '0;
    end else if (advance) begin
      level_valid <= (level_valid << 1) | levels'(in_valid);
    end
  end

endmodule

// File: source/softermax_pow2_bank.sv
//////////////////////////////////////////////////////////////////////
// Softermax power-of-two bank
// Per lane 2^diff from a fraction table and a right shift,
// registered together with the window max
//////////////////////////////////////////////////////////////////////

`include "softermax_cfg.svh"

module softermax_pow2_bank (
  input  logic                    clk,
  input  logic                    rst_n,
  softermax_sub_if.dst            sub,
  output softermax_pkg::smx_out_t out_values [`SMX_PARALLELISM],
  output softermax_pkg::smx_int_t out_max,
  output logic                    out_valid,
  input  logic                    out_ready
);

  localparam int lanes   = `SMX_PARALLELISM;
  localparam int frac_w  = `SMX_IN_FRAC;
  localparam int diff_w  = $bits(softermax_pkg::smx_diff_t);
  localparam int int_w   = diff_w - frac_w;
  localparam int entries = 2 ** frac_w;

  softermax_pkg::smx_out_t frac_table [entries];
  softermax_pkg::smx_out_t pow_value  [lanes];
  logic                    load;

  // Constant table with one entry per fraction code
  for (genvar k = 0; k < entries; k++) begin : g_table
    localparam softermax_pkg::smx_out_t entry = softermax_pkg::pow2_frac_entry(k);
    assign frac_table[k] = entry;
  end

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    logic signed [int_w-1:0] int_part;
    logic [frac_w-1:0]       frac_part;
    logic [int_w-1:0]        shamt;

    // Arithmetic split gives the floor as int_part
    assign int_part  = sub.diff[i][diff_w-1:frac_w];
    assign frac_part = sub.diff[i][frac_w-1:0];
    assign shamt     = -int_part;

    // Everything shifted out gives zero
    assign pow_value[i] = (shamt >= `SMX_OUT_WIDTH) ? '0 : (frac_table[frac_part] >> shamt);

    // A lane exceeds the floored window max by less than one whole unit
    a_diff_nonpos : assert property (@(posedge clk) disable iff (!rst_n)
      sub.valid |-> int_part <= 0);
  end

  assign sub.ready = !out_valid || out_ready;
  assign load      = sub.valid && sub.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (sub.ready) begin
      out_valid <= sub.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_values <= pow_value;
      out_max    <= sub.max;
    end
  end

endmodule

// File: source/softermax_local_window.sv
//////////////////////////////////////////////////////////////////////
// Softermax local window
// Integer local max of each window and per-lane 2^(x - max),
// streamed with valid/ready on both sides
//////////////////////////////////////////////////////////////////////

`include "softermax_cfg.svh"

module softermax_local_window (
  input  logic                    clk,
  input  logic                    rst_n,
  input  softermax_pkg::smx_in_t  in_data [`SMX_PARALLELISM],
  input  logic                    in_valid,
  output logic                    in_ready,
  output softermax_pkg::smx_out_t out_values [`SMX_PARALLELISM],
  output softermax_pkg::smx_int_t out_max,
  output logic                    out_valid,
  input  logic                    out_ready
);

  localparam int lanes  = `SMX_PARALLELISM;
  localparam int in_w   = `SMX_IN_WIDTH;
  localparam int max_w  = `SMX_MAX_WIDTH;
  localparam int diff_w = $bits(softermax_pkg::smx_diff_t);
  localparam int win_w  = lanes * in_w;
  localparam int sub_w  = lanes * diff_w + max_w;

  logic [lanes-1:0]          cast_in_ready;
  logic [lanes-1:0]          cast_out_valid;
  logic                      cast_in_valid;
  logic                      cast_ready;
  logic                      cast_valid;
  softermax_pkg::smx_int_t   cast_data [lanes];
  logic                      tree_in_ready;
  softermax_pkg::smx_int_t   tree_max;
  logic                      tree_out_valid;
  logic                      tree_out_ready;
  logic [win_w-1:0]          fifo_in_data;
  logic [win_w-1:0]          fifo_out_data;
  logic                      fifo_in_valid;
  logic                      fifo_in_ready;
  logic                      fifo_out_valid;
  logic                      fifo_out_ready;
  softermax_pkg::smx_in_t    fifo_lane [lanes];
  softermax_pkg::smx_in_t    max_fixed;
  softermax_pkg::smx_diff_t  sub_diff  [lanes];
  logic [sub_w-1:0]          sub_in_data;
  logic [sub_w-1:0]          sub_out_data;
  logic                      sub_in_valid;
  logic                      sub_in_ready;

  softermax_sub_if sub_if ();

  // Fork to the cast bank and the FIFO, both must take the window
  assign cast_ready    = &cast_in_ready;
  assign cast_in_valid = in_valid && fifo_in_ready;
  assign fifo_in_valid = in_valid && cast_ready;
  assign in_ready      = cast_ready && fifo_in_ready;

  // Upper bits of a two's complement score give its floor
  for (genvar i = 0; i < lanes; i++) begin : g_cast
    assign fifo_in_data[i*in_w +: in_w] = in_data[i];

    skid_buffer #(.width(max_w)) u_cast (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_data   (in_data[i][in_w-1:`SMX_IN_FRAC]),
      .in_valid  (cast_in_valid),
      .in_ready  (cast_in_ready[i]),
      .out_data  (cast_data[i]),
      .out_valid (cast_out_valid[i]),
      .out_ready (tree_in_ready)
    );
  end

  assign cast_valid = &cast_out_valid;

  max_tree u_max_tree (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (cast_data),
    .in_valid  (cast_valid),
    .in_ready  (tree_in_ready),
    .out_data  (tree_max),
    .out_valid (tree_out_valid),
    .out_ready (tree_out_ready)
  );

  // Raw scores wait here for their max
  sync_fifo #(.width(win_w), .depth(`SMX_FIFO_DEPTH)) u_score_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (fifo_in_data),
    .in_valid  (fifo_in_valid),
    .in_ready  (fifo_in_ready),
    .out_data  (fifo_out_data),
    .out_valid (fifo_out_valid),
    .out_ready (fifo_out_ready)
  );

  // Join, both sides pop together
  assign sub_in_valid   = tree_out_valid && fifo_out_valid;
  assign tree_out_ready = sub_in_ready && fifo_out_valid;
  assign fifo_out_ready = sub_in_ready && tree_out_valid;

  // Max aligned to the score's fixed-point format
  assign max_fixed = {tree_max, {`SMX_IN_FRAC{1'b0}}};
  assign sub_in_data[max_w-1:0] = tree_max;

  for (genvar i = 0; i < lanes; i++) begin : g_sub
    assign fifo_lane[i] = fifo_out_data[i*in_w +: in_w];
    assign sub_diff[i]  = softermax_pkg::smx_diff_t'(fifo_lane[i])
                        - softermax_pkg::smx_diff_t'(max_fixed);
    assign sub_in_data[max_w + i*diff_w +: diff_w] = sub_diff[i];
    assign sub_if.diff[i] = sub_out_data[max_w + i*diff_w +: diff_w];
  end

  skid_buffer #(.width(sub_w)) u_sub_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (sub_in_data),
    .in_valid  (sub_in_valid),
    .in_ready  (sub_in_ready),
    .out_data  (sub_out_data),
    .out_valid (sub_if.valid),
    .out_ready (sub_if.ready)
  );

  assign sub_if.max = sub_out_data[max_w-1:0];

  softermax_pow2_bank u_pow2_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .sub        (sub_if),
    .out_values (out_values),
    .out_max    (out_max),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

// File: tb/tb_softermax_local_window.sv
//////////////////////////////////////////////////////////////////////
// Softermax local window testbench
// Random windows checked against a queue model, with reset,
// back-pressure, edge value and throughput tests
//////////////////////////////////////////////////////////////////////

`include "softermax_cfg.svh"

module tb_softermax_local_window;

  localparam int lanes  = `SMX_PARALLELISM;
  localparam int in_w   = `SMX_IN_WIDTH;
  localparam int out_w  = `SMX_OUT_WIDTH;
  localparam int scale  = 2 ** `SMX_IN_FRAC;
  localparam int n_rand = 200;
  localparam int n_bp   = 300;
  localparam int n_edge = 6;
  localparam int n_thru = 64;
  localparam int timeout_limit = 20 * (n_rand + n_bp + n_edge + n_thru) + 1000;
  // Cycles allowed for the last outputs to leave the pipeline
  localparam int drain_limit = 200;
  localparam logic [in_w-1:0] s_min = {1'b1, {(in_w - 1){1'b0}}};
  localparam logic [in_w-1:0] s_max = {1'b0, {(in_w - 1){1'b1}}};

  logic                    clk;
  logic                    rst_n;
  softermax_pkg::smx_in_t  in_data [lanes];
  logic                    in_valid;
  logic                    in_ready;
  softermax_pkg::smx_out_t out_values [lanes];
  softermax_pkg::smx_int_t out_max;
  logic                    out_valid;
  logic                    out_ready;

  logic [31:0]             rng_state;
  int                      pow2_table [scale];
  int                      ready_pct;
  int                      cycle;
  int                      accept_count;
  int                      out_count;
  int                      errors;
  int                      max_errors;
  int                      tests_failed;
  int                      stall_count;
  int                      first_cycle;
  int                      last_cycle;
  logic                    thru_on;
  softermax_pkg::smx_int_t exp_max_q [$];
  logic [lanes*out_w-1:0]  exp_val_q [$];

  softermax_local_window dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_values (out_values),
    .out_max    (out_max),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // 32-bit xorshift with state kept between calls
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [lanes*in_w-1:0] random_window();
    logic [lanes*in_w-1:0] win;
    for (int i = 0; i < lanes; i++) begin
      win[i*in_w +: in_w] = in_w'(next_random());
    end
    return win;
  endfunction

  // Integer division rounded toward minus infinity
  function automatic int floor_div(input int a, input int b);
    if (a >= 0) begin
      return a / b;
    end
    return -((-a + b - 1) / b);
  endfunction

  // 2^(d / scale) in the output format
  // Integer part of d is never positive
  function automatic int lane_value(input int d);
    int ip;
    int frac;
    ip   = floor_div(d, scale);
    frac = d - ip * scale;
    if (-ip >= out_w) begin
      return 0;
    end
    return pow2_table[frac] >> (-ip);
  endfunction

  task automatic check_output();
    softermax_pkg::smx_int_t exp_max;
    logic [lanes*out_w-1:0]  exp_vals;
    if (exp_max_q.size() == 0) begin
      $display("output appeared at cycle %0d with no window outstanding", cycle);
      errors++;
    end else begin
      exp_max  = exp_max_q.pop_front();
      exp_vals = exp_val_q.pop_front();
      if (out_max !== exp_max) begin
        $display("mismatch out_max: expected %h, got %h", exp_max, out_max);
        errors++;
        max_errors++;
      end
      for (int i = 0; i < lanes; i++) begin
        if (out_values[i] !== exp_vals[i*out_w +: out_w]) begin
          $display("mismatch out_values[%0d]: expected %h, got %h",
                   i, exp_vals[i*out_w +: out_w], out_values[i]);
          errors++;
        end
      end
      out_count++;
      if (thru_on) begin
        last_cycle = cycle;
      end
    end
  endtask

  // Model takes each accepted window and the scoreboard each output
  always @(posedge clk) begin : monitor
    int                     win_max;
    logic [lanes*out_w-1:0] vals;
    cycle = cycle + 1;
    if (thru_on && in_valid && !in_ready) begin
      stall_count++;
    end
    if (rst_n && in_valid && in_ready) begin
      win_max = floor_div(int'(in_data[0]), scale);
      for (int i = 1; i < lanes; i++) begin
        if (floor_div(int'(in_data[i]), scale) > win_max) begin
          win_max = floor_div(int'(in_data[i]), scale);
        end
      end
      for (int i = 0; i < lanes; i++) begin
        vals[i*out_w +: out_w] = out_w'(lane_value(int'(in_data[i]) - win_max * scale));
      end
      exp_max_q.push_back(softermax_pkg::smx_int_t'(win_max));
      exp_val_q.push_back(vals);
      accept_count++;
      if (thru_on && first_cycle < 0) begin
        first_cycle = cycle;
      end
    end
    if (rst_n && out_valid && out_ready) begin
      check_output();
    end
  end

  task automatic next_cycle();
    @(negedge clk);
    out_ready = ((next_random() % 100) < ready_pct);
  endtask

  // Random idle cycles first and then the window held until taken
  task automatic send_window(input logic [lanes*in_w-1:0] win, input int gap_pct);
    int target;
    while ((next_random() % 100) < gap_pct) begin
      in_valid = 1'b0;
      next_cycle();
    end
    for (int i = 0; i < lanes; i++) begin
      in_data[i] = win[i*in_w +: in_w];
    end
    in_valid = 1'b1;
    target   = accept_count + 1;
    next_cycle();
    while (accept_count < target) begin
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  // Outstanding outputs get at most drain_limit cycles
  task automatic drain();
    int waited;
    waited = 0;
    while (out_count < accept_count && waited < drain_limit) begin
      next_cycle();
      waited++;
    end
    repeat (8) next_cycle();
  endtask

  task automatic check_count(input int expected, input int base_out);
    if (out_count - base_out != expected) begin
      $display("sent %0d windows but received %0d", expected, out_count - base_out);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errs);
      tests_failed++;
    end
  endtask

  initial begin
    int                    base_err;
    int                    base_max;
    int                    base_out;
    logic [lanes*in_w-1:0] edge_win [n_edge];
    rng_state = 32'd68;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    thru_on   = 1'b0;
    ready_pct = 100;
    for (int i = 0; i < lanes; i++) begin
      in_data[i] = '0;
    end
    for (int k = 0; k < scale; k++) begin
      pow2_table[k] = $rtoi($pow(2.0, real'(k) / real'(scale)) * (2 ** `SMX_OUT_FRAC) + 0.5);
    end

    base_err = errors;
    repeat (16) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("mismatch out_valid: expected 0, got %h during reset", out_valid);
        errors++;
      end
    end
    rst_n = 1'b1;
    next_cycle();
    if (out_valid !== 1'b0) begin
      $display("mismatch out_valid: expected 0, got %h after reset", out_valid);
      errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("mismatch in_ready: expected 1, got %h after reset", in_ready);
      errors++;
    end
    report_test("reset", errors - base_err);

    base_err  = errors;
    base_max  = max_errors;
    base_out  = out_count;
    repeat (n_rand) send_window(random_window(), 30);
    drain();
    check_count(n_rand, base_out);
    report_test("maximum", max_errors - base_max);
    report_test("lane values", errors - base_err - (max_errors - base_max));

    base_err  = errors;
    base_out  = out_count;
    ready_pct = 40;
    repeat (n_bp) send_window(random_window(), 40);
    drain();
    check_count(n_bp, base_out);
    if (exp_max_q.size() != 0) begin
      $display("model still holds %0d windows after the outputs stopped", exp_max_q.size());
      errors++;
    end
    report_test("back-pressure", errors - base_err);

    // Equal lanes of 1.0 and then the score extremes
    edge_win[0] = {lanes{in_w'(scale)}};
    edge_win[1] = {lanes{s_min}};
    edge_win[2] = {lanes{s_max}};
    edge_win[3] = {{(lanes - 1){s_min}}, s_max};
    edge_win[4] = {{(lanes - 1){s_max}}, s_min};
    for (int i = 0; i < lanes; i++) begin
      edge_win[5][i*in_w +: in_w] = (i % 2 == 0) ? s_min : s_max;
    end
    base_err  = errors;
    base_out  = out_count;
    ready_pct = 60;
    for (int w = 0; w < n_edge; w++) begin
      send_window(edge_win[w], 0);
    end
    drain();
    check_count(n_edge, base_out);
    report_test("edge cases", errors - base_err);

    base_err  = errors;
    base_out  = out_count;
    ready_pct = 100;
    repeat (4) next_cycle();
    stall_count = 0;
    first_cycle = -1;
    thru_on     = 1'b1;
    repeat (n_thru) send_window(random_window(), 0);
    drain();
    thru_on = 1'b0;
    check_count(n_thru, base_out);
    if (stall_count != 0) begin
      $display("in_ready dropped on %0d cycles with in_valid held high", stall_count);
      errors++;
    end
    if (last_cycle - first_cycle > n_thru + 10) begin
      $display("outputs took %0d cycles, more than %0d", last_cycle - first_cycle, n_thru + 10);
      errors++;
    end
    report_test("throughput", errors - base_err);

    $display("tests failed %0d of 6, windows %0d, errors %0d", tests_failed, out_count, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    while (cycle < timeout_limit) begin
      @(negedge clk);
    end
    $display("timeout after %0d cycles with %0d windows outstanding", cycle, exp_max_q.size());
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
source/softermax_pkg.sv
source/softermax_sub_if.sv
source/skid_buffer.sv
source/sync_fifo.sv
source/max_tree.sv
source/softermax_pow2_bank.sv
source/softermax_local_window.sv
tb/tb_softermax_local_window.sv

// File: Bender.yml
package:
  name: softermax_local_window

sources:
  - include_dirs:
      - include
    files:
      - source/softermax_pkg.sv
      - source/softermax_sub_if.sv
      - source/skid_buffer.sv
      - source/sync_fifo.sv
      - source/max_tree.sv
      - source/softermax_pow2_bank.sv
      - source/softermax_local_window.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_softermax_local_window.sv
